//--- rtl/csc_pkg.sv
package csc_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////

	// one colour component
	localparam int PIX_W = 8;
	// two's complement width of terms and sums
	localparam int ACC_W = 10;

	// input register to output register
	localparam int LATENCY = 5;

	// u and v sit around mid scale
	localparam int C_OFFSET = 128;

	typedef logic [PIX_W-1:0] pix_t;
	typedef logic signed [ACC_W-1:0] term_t;

	// clamp view of a finished sum
	// sign set means negative, over set means 256 or more
	typedef struct packed {
		logic sign;
		logic over;
		pix_t pix;
	} acc_fields_t;

	// adder writes val, clamp reads f
	typedef union packed {
		logic signed [ACC_W-1:0] val;
		acc_fields_t f;
	} acc_u;

	//////////////////////////////
	// matrix
	//////////////////////////////

	// units of 1/256
	// rows y u v, columns r g b
	localparam int COEF [0:2][0:2] = '{
		'{ 77,  150,   29},
		'{-38,  -74,  112},
		'{157, -132,  -26}
	};

	// one table entry
	// coefficient times component, rounded to nearest
	// arithmetic shift keeps negative terms rounding down
	function automatic term_t coef_term(input int coef, input pix_t pix);
		int prod;
		prod = coef * int'(pix) + 128;
		return term_t'(prod >>> 8);
	endfunction

endpackage

//--- rtl/csc_if.sv
`timescale 1ns/1ps

//////////////////////////////
// registered input pixel
//////////////////////////////

interface pixel_if;
	import csc_pkg::*;

	// strobe travels with the pixel
	logic de;
	pix_t r;
	pix_t g;
	pix_t b;

	// producer side
	modport src (output de, r, g, b);
	// consumer side
	modport dst (input de, r, g, b);

endinterface

//////////////////////////////
// sums ahead of the clamp
//////////////////////////////

interface acc_if;
	import csc_pkg::*;

	// one strobe for all three channels
	logic de;
	// signed sums, offsets already added
	acc_u y;
	acc_u u;
	acc_u v;

	// adder tree drives
	modport src (output de, y, u, v);
	// clamp reads
	modport dst (input de, y, u, v);

endinterface

//--- rtl/csc_coef_lut.sv
`timescale 1ns/1ps

module csc_coef_lut
#(
	// 0 r, 1 g, 2 b
	parameter int COL = 0
)
(
	input	logic					i_pclk,
	input	logic					i_arst,
	input	csc_pkg::pix_t			i_pix,
	// y, u, v products of this column
	output	csc_pkg::term_t [2:0]	o_term
);
	import csc_pkg::*;

	// only three columns in the matrix
	if (COL < 0 || COL > 2)
	begin : g_bad_col
		$error("csc_coef_lut COL out of range");
	end

	// one 256 entry table per output channel
	term_t w_rom [0:2][0:2**PIX_W-1];

	//////////////////////////////
	// table contents
	//////////////////////////////

	// constants only, folded at elaboration
	for (genvar ch = 0; ch < 3; ch++)
	begin : g_ch
		for (genvar a = 0; a < 2**PIX_W; a++)
		begin : g_addr
			assign w_rom[ch][a] = coef_term(COEF[ch][COL], pix_t'(a));
		end
	end

	// registered read port, same address into all three
	always_ff @(posedge i_pclk or posedge i_arst)
	begin
		if (i_arst)
		begin
			o_term <= '0;
		end
		else
		begin
			for (int ch = 0; ch < 3; ch++)
			begin
				o_term[ch] <= w_rom[ch][i_pix];
			end
		end
	end

endmodule

//--- rtl/csc_input_stage.sv
`timescale 1ns/1ps

module csc_input_stage
(
	input	logic							i_pclk,
	input	logic							i_arst,
	input	logic							i_de,
	input	csc_pkg::pix_t					i_r,
	input	csc_pkg::pix_t					i_g,
	input	csc_pkg::pix_t					i_b,
	// de aligned with the table outputs
	output	logic							o_de,
	// indexed [channel][column]
	output	csc_pkg::term_t [2:0][2:0]		o_term
);
	import csc_pkg::*;

	// registered pixel feeding the tables
	pixel_if u_pix ();

	// component per column, r g b
	pix_t w_col_pix [3];
	// table outputs, indexed [column][channel]
	term_t [2:0][2:0] w_col_term;

	//////////////////////////////
	// input registers
	//////////////////////////////

	always_ff @(posedge i_pclk or posedge i_arst)
	begin
		if (i_arst)
		begin
			u_pix.de	<= 1'b0;
			u_pix.r		<= '0;
			u_pix.g		<= '0;
			u_pix.b		<= '0;
			o_de		<= 1'b0;
		end
		else
		begin
			u_pix.de	<= i_de;
			u_pix.r		<= i_r;
			u_pix.g		<= i_g;
			u_pix.b		<= i_b;
			// one more cycle for the table read
			o_de		<= u_pix.de;
		end
	end

	assign w_col_pix[0] = u_pix.r;
	assign w_col_pix[1] = u_pix.g;
	assign w_col_pix[2] = u_pix.b;

	// one table per input component
	for (genvar c = 0; c < 3; c++)
	begin : g_lut
		csc_coef_lut #(.COL(c)) u_lut
		(
			.i_pclk	(i_pclk),
			.i_arst	(i_arst),
			.i_pix	(w_col_pix[c]),
			.o_term	(w_col_term[c])
		);
	end

	// regroup per output channel for the adder tree
	always_comb
	begin
		for (int ch = 0; ch < 3; ch++)
		begin
			for (int c = 0; c < 3; c++)
			begin
				o_term[ch][c] = w_col_term[c][ch];
			end
		end
	end

	// valid pixels must be fully driven
	a_pix_known : assert property (@(posedge i_pclk) disable iff (i_arst)
		i_de |-> !$isunknown({i_r, i_g, i_b}));

endmodule

//--- rtl/csc_matrix_sum.sv
`timescale 1ns/1ps

module csc_matrix_sum
#(
	// luma offset, 0 full range or 16 video range
	parameter int Y_OFFSET = 0
)
(
	input	logic							i_pclk,
	input	logic							i_arst,
	input	logic							i_de,
	// indexed [channel][column]
	input	csc_pkg::term_t [2:0][2:0]		i_term,
	acc_if.src								o_acc
);
	import csc_pkg::*;

	if (Y_OFFSET != 0 && Y_OFFSET != 16)
	begin : g_bad_offset
		$error("csc_matrix_sum Y_OFFSET must be 0 or 16");
	end

	// y first, then u and v
	localparam term_t OFFS [3] = '{term_t'(Y_OFFSET), term_t'(C_OFFSET), term_t'(C_OFFSET)};

	// first adder level
	logic	r_de_a;
	term_t	r_part [3];
	// b term held back one cycle to meet its partial sum
	term_t	r_b [3];
	// second adder level
	logic	r_de_b;
	acc_u	r_acc [3];

	//////////////////////////////
	// adder tree
	//////////////////////////////

	always_ff @(posedge i_pclk or posedge i_arst)
	begin
		if (i_arst)
		begin
			r_de_a <= 1'b0;
			r_de_b <= 1'b0;
			for (int ch = 0; ch < 3; ch++)
			begin
				r_part[ch]	<= '0;
				r_b[ch]		<= '0;
				r_acc[ch]	<= '0;
			end
		end
		else
		begin
			r_de_a <= i_de;
			r_de_b <= r_de_a;
			for (int ch = 0; ch < 3; ch++)
			begin
				// r plus g
				r_part[ch]		<= i_term[ch][0] + i_term[ch][1];
				r_b[ch]			<= i_term[ch][2];
				// plus b and the channel offset, signed view
				r_acc[ch].val	<= r_part[ch] + r_b[ch] + OFFS[ch];
			end
		end
	end

	assign o_acc.de	= r_de_b;
	assign o_acc.y	= r_acc[0];
	assign o_acc.u	= r_acc[1];
	assign o_acc.v	= r_acc[2];

endmodule

//--- rtl/csc_clamp.sv
`timescale 1ns/1ps

module csc_clamp
(
	input	logic				i_pclk,
	input	logic				i_arst,
	acc_if.dst					i_acc,
	output	logic				o_de,
	output	csc_pkg::pix_t		o_y,
	output	csc_pkg::pix_t		o_u,
	output	csc_pkg::pix_t		o_v
);
	import csc_pkg::*;

	// saturate a sum to 0..255
	// negative wins over the over bit
	// both bits are set from -256 to -1
	function automatic pix_t sat(input acc_u a);
		if (a.f.sign)
			return '0;
		else if (a.f.over)
			return '1;
		else
			return a.f.pix;
	endfunction

	//////////////////////////////
	// output registers
	//////////////////////////////

	always_ff @(posedge i_pclk or posedge i_arst)
	begin
		if (i_arst)
		begin
			o_de	<= 1'b0;
			o_y		<= '0;
			o_u		<= '0;
			o_v		<= '0;
		end
		else
		begin
			o_de	<= i_acc.de;
			o_y		<= sat(i_acc.y);
			o_u		<= sat(i_acc.u);
			o_v		<= sat(i_acc.v);
		end
	end

	// positive overflow pins to full scale a cycle later
	a_y_high : assert property (@(posedge i_pclk) disable iff (i_arst)
		(!i_acc.y.f.sign && i_acc.y.f.over) |=> (o_y == 8'hff));
	a_u_high : assert property (@(posedge i_pclk) disable iff (i_arst)
		(!i_acc.u.f.sign && i_acc.u.f.over) |=> (o_u == 8'hff));
	a_v_high : assert property (@(posedge i_pclk) disable iff (i_arst)
		(!i_acc.v.f.sign && i_acc.v.f.over) |=> (o_v == 8'hff));

	// no output strobe while held in reset
	a_de_rst : assert property (@(posedge i_pclk) i_arst |-> !o_de);

endmodule

//--- rtl/csc_top.sv
`timescale 1ns/1ps

module csc_top
#(
	// luma offset, passed to the adder tree
	parameter int Y_OFFSET = 0
)
(
	input	logic				i_pclk,
	input	logic				i_arst,
	input	logic				i_de,
	input	csc_pkg::pix_t		i_r,
	input	csc_pkg::pix_t		i_g,
	input	csc_pkg::pix_t		i_b,
	output	logic				o_de,
	output	csc_pkg::pix_t		o_y,
	output	csc_pkg::pix_t		o_u,
	output	csc_pkg::pix_t		o_v
);
	import csc_pkg::*;

	// table products, two cycles after the input edge
	logic				w_term_de;
	term_t [2:0][2:0]	w_term;

	// signed sums into the clamp
	acc_if u_acc ();

	//////////////////////////////
	// pipeline
	//////////////////////////////

	// input registers and lookups, 2 cycles
	csc_input_stage u_input_stage
	(
		.i_pclk	(i_pclk),
		.i_arst	(i_arst),
		.i_de	(i_de),
		.i_r	(i_r),
		.i_g	(i_g),
		.i_b	(i_b),
		.o_de	(w_term_de),
		.o_term	(w_term)
	);

	// two level adder tree, 2 cycles
	csc_matrix_sum #(.Y_OFFSET(Y_OFFSET)) u_matrix_sum
	(
		.i_pclk	(i_pclk),
		.i_arst	(i_arst),
		.i_de	(w_term_de),
		.i_term	(w_term),
		.o_acc	(u_acc.src)
	);

	// saturation and output registers, 1 cycle
	csc_clamp u_clamp
	(
		.i_pclk	(i_pclk),
		.i_arst	(i_arst),
		.i_acc	(u_acc.dst),
		.o_de	(o_de),
		.o_y	(o_y),
		.o_u	(o_u),
		.o_v	(o_v)
	);

	// strobe pattern comes out unchanged, LATENCY edges later
	a_de_out : assert property (@(posedge i_pclk) disable iff (i_arst)
		i_de |-> ##LATENCY o_de);
	a_gap_out : assert property (@(posedge i_pclk) disable iff (i_arst)
		!i_de |-> ##LATENCY !o_de);

endmodule

//--- test/tb_csc_model.svh
`ifndef TB_CSC_MODEL_SVH
`define TB_CSC_MODEL_SVH

//////////////////////////////
// reference model
//////////////////////////////

// bt.601 matrix in 1/256 units, rows y u v, columns r g b
localparam int REF_COEF [0:2][0:2] = '{
	'{ 77,  150,   29},
	'{-38,  -74,  112},
	'{157, -132,  -26}
};

// y offset follows the dut parameter, chroma sits at mid scale
localparam int REF_OFFSET [0:2] = '{TB_Y_OFFSET, 128, 128};

// one expected output pixel, due at a monitor cycle
typedef struct {
	int		due;
	pix_t	y;
	pix_t	u;
	pix_t	v;
} exp_t;

exp_t	exp_q [$];
int		n_checked = 0;

// product rounded to nearest, floor for negatives
function automatic int ref_term(input int coef, input pix_t pix);
	return (coef * int'(pix) + 128) >>> 8;
endfunction

// full channel, summed then saturated both ways
function automatic pix_t ref_channel(input int ch, input pix_t r, input pix_t g, input pix_t b);
	int sum;
	sum = ref_term(REF_COEF[ch][0], r) + ref_term(REF_COEF[ch][1], g);
	sum = sum + ref_term(REF_COEF[ch][2], b) + REF_OFFSET[ch];
	if (sum < 0)
		return 8'd0;
	else if (sum > 255)
		return 8'd255;
	else
		return pix_t'(sum);
endfunction

task automatic push_expected(input pix_t r, input pix_t g, input pix_t b, input int due);
	exp_t e;
	e.due = due;
	e.y = ref_channel(0, r, g, b);
	e.u = ref_channel(1, r, g, b);
	e.v = ref_channel(2, r, g, b);
	exp_q.push_back(e);
endtask

//////////////////////////////
// compare tasks
//////////////////////////////

task automatic check_pix(input string what, input pix_t exp, input pix_t act);
	if (act !== exp)
	begin
		$display("ERROR %s %s: expected %0d, actual %0d", test_name, what, exp, act);
		report_fail();
	end
endtask

task automatic check_de(input string what, input logic exp, input logic act);
	if (act !== exp)
	begin
		$display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
		report_fail();
	end
endtask

`endif

//--- test/tb_csc_top.sv
`timescale 1ns/1ps

module tb_csc_top;
	import csc_pkg::*;

	localparam int TB_Y_OFFSET = 0;
	localparam int RST_CYC = 16;
	localparam int N_RAND = 2000;
	localparam int N_CORNER = 5;
	localparam int N_BURST = 64;
	// reset mid-stream, pixels before, cycles held, pixels after
	localparam int N_PRE = 12;
	localparam int RST_MID = 3;
	localparam int N_POST = 32;
	// random phase takes at most two cycles per pixel
	// each corner and each drain costs latency plus a few
	localparam int MAX_CYCLES = RST_CYC + 2 * N_RAND + N_CORNER * (LATENCY + 3)
		+ N_BURST + N_PRE + RST_MID + N_POST + 4 * (LATENCY + 2) + 50;
	localparam int MIN_CHECKED = N_RAND + N_CORNER + N_BURST + N_POST;

	logic	i_pclk = 1'b0;
	logic	i_arst;
	logic	i_de;
	pix_t	i_r;
	pix_t	i_g;
	pix_t	i_b;
	logic	o_de;
	pix_t	o_y;
	pix_t	o_u;
	pix_t	o_v;

	int		cyc = 0;
	string	test_name = "reset";

	task automatic report_fail();
		$display("tests failed");
		$fatal(1);
	endtask

	`include "tb_csc_model.svh"

	csc_top #(.Y_OFFSET(TB_Y_OFFSET)) u_csc_top
	(
		.i_pclk	(i_pclk),
		.i_arst	(i_arst),
		.i_de	(i_de),
		.i_r	(i_r),
		.i_g	(i_g),
		.i_b	(i_b),
		.o_de	(o_de),
		.o_y	(o_y),
		.o_u	(o_u),
		.o_v	(o_v)
	);

	// 4 ns period
	always #2 i_pclk = ~i_pclk;

	// cycle count and run limit
	always @(posedge i_pclk)
	begin
		cyc <= cyc + 1;
		if (cyc >= MAX_CYCLES)
		begin
			$display("run timed out after %0d cycles, output pixels still missing", cyc);
			report_fail();
		end
	end

	//////////////////////////////
	// monitor, mid cycle
	//////////////////////////////

	// inputs seen here are sampled at the next edge
	// so their output shows LATENCY monitor cycles later
	always @(negedge i_pclk)
	begin
		if (i_arst)
		begin
			// in flight pixels are lost
			exp_q.delete();
			check_de("o_de in reset", 1'b0, o_de);
		end
		else
		begin
			if (exp_q.size() > 0 && exp_q[0].due == cyc)
			begin
				check_de("o_de", 1'b1, o_de);
				check_pix("o_y", exp_q[0].y, o_y);
				check_pix("o_u", exp_q[0].u, o_u);
				check_pix("o_v", exp_q[0].v, o_v);
				void'(exp_q.pop_front());
				n_checked++;
			end
			else
				check_de("o_de gap", 1'b0, o_de);
			if (i_de)
				push_expected(i_r, i_g, i_b, cyc + LATENCY);
		end
	end

	//////////////////////////////
	// stimulus tasks
	//////////////////////////////

	task automatic drive_pixel(input pix_t r, input pix_t g, input pix_t b);
		@(posedge i_pclk);
		i_de <= 1'b1;
		i_r <= r;
		i_g <= g;
		i_b <= b;
	endtask

	task automatic drive_random_pixel();
		drive_pixel(pix_t'($urandom), pix_t'($urandom), pix_t'($urandom));
	endtask

	// data keeps moving while de is low
	task automatic drive_idle();
		@(posedge i_pclk);
		i_de <= 1'b0;
		i_r <= pix_t'($urandom);
		i_g <= pix_t'($urandom);
		i_b <= pix_t'($urandom);
	endtask

	// idle until the model has nothing left in flight
	task automatic drain();
		drive_idle();
		while (exp_q.size() != 0)
			drive_idle();
	endtask

	// one pixel, wait for its strobe, compare with known values
	task automatic check_corner(input string what, input pix_t r, input pix_t g, input pix_t b,
		input pix_t y, input pix_t u, input pix_t v);
		test_name = what;
		drive_pixel(r, g, b);
		do
		begin
			drive_idle();
			@(negedge i_pclk);
		end
		while (!o_de);
		check_pix("o_y", y, o_y);
		check_pix("o_u", u, o_u);
		check_pix("o_v", v, o_v);
	endtask

	initial
	begin
		void'($urandom(83));
		i_arst = 1'b1;
		i_de = 1'b0;
		i_r = '0;
		i_g = '0;
		i_b = '0;
		repeat (RST_CYC) @(posedge i_pclk);
		i_arst <= 1'b0;

		// about 70 percent de, single cycle gaps
		test_name = "random";
		for (int i = 0; i < N_RAND; i++)
		begin
			if ($urandom_range(9) < 4)
				drive_idle();
			drive_random_pixel();
		end
		drain();

		// black, white, grey, then both saturation sides on v
		check_corner("black", 8'd0, 8'd0, 8'd0, 8'd0, 8'd128, 8'd128);
		check_corner("white", 8'd255, 8'd255, 8'd255, 8'd255, 8'd128, 8'd127);
		check_corner("grey", 8'd128, 8'd128, 8'd128, 8'd129, 8'd128, 8'd128);
		check_corner("red", 8'd255, 8'd0, 8'd0, 8'd77, 8'd90, 8'd255);
		check_corner("green", 8'd0, 8'd255, 8'd0, 8'd149, 8'd54, 8'd0);
		drain();

		// de held high, monitor sees one output per cycle
		test_name = "burst";
		repeat (N_BURST) drive_random_pixel();
		drain();

		// reset lands while pixels are still in the pipeline
		test_name = "reset_mid";
		repeat (N_PRE) drive_random_pixel();
		@(posedge i_pclk);
		i_arst <= 1'b1;
		repeat (RST_MID) drive_random_pixel();
		// strobe already low at the release edge
		drive_idle();
		@(posedge i_pclk);
		i_arst <= 1'b0;
		repeat (N_POST) drive_random_pixel();
		drain();

		test_name = "end";
		if (exp_q.size() == 0 && n_checked >= MIN_CHECKED)
		begin
			$display("all tests passed");
			$finish;
		end
		else
		begin
			$display("only %0d output pixels were checked, %0d were still expected",
				n_checked, exp_q.size());
			report_fail();
		end
	end

endmodule

//--- compile.f
+incdir+test
rtl/csc_pkg.sv
rtl/csc_if.sv
rtl/csc_coef_lut.sv
rtl/csc_input_stage.sv
rtl/csc_matrix_sum.sv
rtl/csc_clamp.sv
rtl/csc_top.sv
test/tb_csc_top.sv

//--- Makefile
# Verilator build and run of the csc testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f compile.f --top-module tb_csc_top -Mdir obj_dir
	./obj_dir/Vtb_csc_top | tee $(LOG)
	@grep -qx "all tests passed" $(LOG) || (echo "FAIL, see $(LOG)" && exit 1)
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)
